// File: src/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Width of a data word and of every register
`define XLEN 32

// Instruction memory depth in 32-bit words
`define IMEM_WORDS 64

// Word index width for instruction memory
`define IMEM_AW $clog2(`IMEM_WORDS)

// Data memory depth in 32-bit words
`define DMEM_WORDS 64

// Word index width for data memory
`define DMEM_AW $clog2(`DMEM_WORDS)

// First fetch address after reset, also the wrap target
`define RESET_PC 32'h0000_0000

`endif

// File: src/isa_pkg.sv
package isa_pkg;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // Register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // Register-immediate ALU
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // funct3 values of the ALU group
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010;  // LW and SW

    localparam logic [6:0] F7_NORMAL  = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;  // SUB, SRA, SRAI

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;  // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;  // imm[4:0]
        logic [6:0] opcode;
    } s_fmt_t;

    // One instruction word, viewed per format
    typedef union packed {
        r_fmt_t      r;
        i_fmt_t      i;
        s_fmt_t      s;
        logic [31:0] raw;
    } inst_u;

endpackage

// File: src/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;  // Operand b from immediate
        logic    reg_we;
        logic    mem_rd;
        logic    mem_wr;
    } ctrl_t;

    // One retired instruction
    typedef struct packed {
        logic [31:0]       pc;
        logic [31:0]       inst;
        logic [4:0]        rd;
        logic              rd_we;
        logic [`XLEN-1:0] rd_data;
    } commit_t;

    typedef struct packed {
        logic                en;
        logic [`IMEM_AW-1:0] addr;  // Word index
        logic [31:0]         data;
    } imem_wr_t;

    typedef struct packed {
        logic [31:0] addr;  // Byte address
    } host_req_t;

    typedef struct packed {
        logic [`XLEN-1:0] data;
    } host_rsp_t;

endpackage

// File: src/fetch_unit.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module fetch_unit import isa_pkg::*, cpu_pkg::*; (
    input  logic        CLK,
    input  logic        RST,
    input  logic        run,
    input  imem_wr_t    imem_wr,
    output logic [31:0] pc,
    output inst_u       inst
);

    logic [31:0]             imem [`IMEM_WORDS];
    logic [`IMEM_WORDS-1:0]  loaded;  // Word has been written since reset
    logic [`IMEM_AW-1:0]     pc_idx;

    assign pc_idx = pc[`IMEM_AW+1:2];

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= `RESET_PC;
        end else if (run) begin
            if (pc_idx == `IMEM_AW'(`IMEM_WORDS - 1))
                pc <= `RESET_PC;  // Wrap at end of memory
            else
                pc <= pc + 32'd4;
        end
    end

    // Program load, only while halted
    always_ff @(posedge CLK) begin
        if (RST) begin
            loaded <= '0;
        end else if (imem_wr.en && !run) begin
            loaded[imem_wr.addr] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (imem_wr.en && !run)
            imem[imem_wr.addr] <= imem_wr.data;
    end

    // All-zero word decodes as a no-op
    assign inst.raw = loaded[pc_idx] ? imem[pc_idx] : 32'h0;

endmodule

// File: src/decoder.sv
`timescale 1ns/1ns

module decoder import isa_pkg::*, cpu_pkg::*; (
    input  inst_u       inst,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [4:0]  rd,
    output logic [31:0] imm,
    output ctrl_t       ctrl
);

    logic illegal;

    always_comb begin
        rs1     = inst.r.rs1;
        rs2     = inst.r.rs2;
        rd      = '0;
        imm     = '0;
        ctrl    = '0;
        illegal = 1'b0;

        case (inst.r.opcode)
            OPC_OP: begin
                rd          = inst.r.rd;
                ctrl.reg_we = 1'b1;
                case (inst.r.funct3)
                    F3_ADD_SUB: ctrl.alu_op = (inst.r.funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     ctrl.alu_op = ALU_SLL;
                    F3_SLT:     ctrl.alu_op = ALU_SLT;
                    F3_SLTU:    ctrl.alu_op = ALU_SLTU;
                    F3_XOR:     ctrl.alu_op = ALU_XOR;
                    F3_SRL_SRA: ctrl.alu_op = (inst.r.funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:      ctrl.alu_op = ALU_OR;
                    default:    ctrl.alu_op = ALU_AND;
                endcase
                // Alternate funct7 only exists for SUB and SRA
                if (inst.r.funct7 == F7_ALT)
                    illegal = !(inst.r.funct3 inside {F3_ADD_SUB, F3_SRL_SRA});
                else
                    illegal = (inst.r.funct7 != F7_NORMAL);
            end
            OPC_OP_IMM: begin
                rs1          = inst.i.rs1;
                rd           = inst.i.rd;
                imm          = {{20{inst.i.imm12[11]}}, inst.i.imm12};
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
                case (inst.i.funct3)
                    F3_ADD_SUB: ctrl.alu_op = ALU_ADD;
                    F3_SLL:     ctrl.alu_op = ALU_SLL;
                    F3_SLT:     ctrl.alu_op = ALU_SLT;
                    F3_SLTU:    ctrl.alu_op = ALU_SLTU;
                    F3_XOR:     ctrl.alu_op = ALU_XOR;
                    F3_SRL_SRA: ctrl.alu_op = inst.raw[30] ? ALU_SRA : ALU_SRL;
                    F3_OR:      ctrl.alu_op = ALU_OR;
                    default:    ctrl.alu_op = ALU_AND;
                endcase
                // Shift immediates carry funct7 in imm[11:5]
                if (inst.i.funct3 == F3_SLL)
                    illegal = (inst.i.imm12[11:5] != F7_NORMAL);
                else if (inst.i.funct3 == F3_SRL_SRA)
                    illegal = !(inst.i.imm12[11:5] inside {F7_NORMAL, F7_ALT});
            end
            OPC_LOAD: begin
                rs1          = inst.i.rs1;
                rd           = inst.i.rd;
                imm          = {{20{inst.i.imm12[11]}}, inst.i.imm12};
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
                ctrl.mem_rd  = 1'b1;
                illegal      = (inst.i.funct3 != F3_WORD);  // LW only
            end
            OPC_STORE: begin
                rs1          = inst.s.rs1;
                rs2          = inst.s.rs2;
                imm          = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
                ctrl.use_imm = 1'b1;
                ctrl.mem_wr  = 1'b1;
                illegal      = (inst.s.funct3 != F3_WORD);  // SW only
            end
            default: illegal = 1'b1;
        endcase

        if (illegal) begin
            rd   = '0;
            ctrl = '0;  // Retire as a no-op
        end
    end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module reg_file (
    input  logic             CLK,
    input  logic             RST,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  logic [4:0]       rd,
    input  logic             we,
    input  logic [`XLEN-1:0] wdata,
    output logic [`XLEN-1:0] rs1_data,
    output logic [`XLEN-1:0] rs2_data
);

    logic [`XLEN-1:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: src/alu.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module alu import cpu_pkg::*; (
    input  alu_op_t          op,
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    output logic [`XLEN-1:0] y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // Shift amount from low bits only

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_SLL:  y = a << shamt;
            ALU_SLT:  y = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: y = {31'd0, a < b};
            ALU_XOR:  y = a ^ b;
            ALU_SRL:  y = a >> shamt;
            ALU_SRA:  y = $unsigned($signed(a) >>> shamt);  // Sign fills
            ALU_OR:   y = a | b;
            ALU_AND:  y = a & b;
            default:  y = '0;
        endcase
    end

endmodule

// File: src/data_mem.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module data_mem import cpu_pkg::*; (
    input  logic             CLK,
    input  logic             RST,
    input  logic             mem_rd,
    input  logic             mem_wr,
    input  logic [31:0]      addr,
    input  logic [`XLEN-1:0] wdata,
    output logic [`XLEN-1:0] rdata,
    input  logic             host_valid,
    input  host_req_t        host_req,
    output logic             host_ready,
    output logic             host_rsp_valid,
    output host_rsp_t        host_rsp
);

    logic [`XLEN-1:0]    mem [`DMEM_WORDS];
    logic [`DMEM_AW-1:0] core_idx;
    logic [`DMEM_AW-1:0] host_idx;
    logic                host_accept;

    assign core_idx = addr[`DMEM_AW+1:2];           // Word index, wraps
    assign host_idx = host_req.addr[`DMEM_AW+1:2];

    // Host waits out any core store
    assign host_ready  = !mem_wr;
    assign host_accept = host_valid && host_ready;

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < `DMEM_WORDS; i++)
                mem[i] <= '0;
        end else if (mem_wr) begin
            mem[core_idx] <= wdata;
        end
    end

    assign rdata = mem_rd ? mem[core_idx] : '0;

    always_ff @(posedge CLK) begin
        if (RST)
            host_rsp_valid <= 1'b0;
        else
            host_rsp_valid <= host_accept;
    end

    always_ff @(posedge CLK) begin
        if (host_accept)
            host_rsp.data <= mem[host_idx];
    end

endmodule

// File: src/single_cpu.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module single_cpu import isa_pkg::*, cpu_pkg::*; (
    input  logic      CLK,
    input  logic      RST,
    input  logic      run,
    input  imem_wr_t  imem_wr,
    input  logic      host_valid,
    input  host_req_t host_req,
    output logic      host_ready,
    output logic      host_rsp_valid,
    output host_rsp_t host_rsp,
    output logic      commit_valid,
    output commit_t   commit
);

    logic [31:0]       pc;
    inst_u             inst;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [4:0]        rd;
    logic [31:0]       imm;
    ctrl_t             ctrl;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_y;
    logic [`XLEN-1:0] load_data;
    logic [`XLEN-1:0] wb_data;
    logic              rd_we;
    logic              store_en;

    fetch_unit fetch_unit_inst (
        .CLK     (CLK),
        .RST     (RST),
        .run     (run),
        .imem_wr (imem_wr),
        .pc      (pc),
        .inst    (inst)
    );

    decoder decoder_inst (
        .inst (inst),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd),
        .imm  (imm),
        .ctrl (ctrl)
    );

    // Nothing is written while halted
    assign rd_we    = run && ctrl.reg_we && (rd != 5'd0);
    assign store_en = run && ctrl.mem_wr;

    reg_file reg_file_inst (
        .CLK      (CLK),
        .RST      (RST),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .we       (rd_we),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign alu_b = ctrl.use_imm ? imm : rs2_data;

    alu alu_inst (
        .op (ctrl.alu_op),
        .a  (rs1_data),
        .b  (alu_b),
        .y  (alu_y)
    );

    data_mem data_mem_inst (
        .CLK            (CLK),
        .RST            (RST),
        .mem_rd         (ctrl.mem_rd),
        .mem_wr         (store_en),
        .addr           (alu_y),
        .wdata          (rs2_data),
        .rdata          (load_data),
        .host_valid     (host_valid),
        .host_req       (host_req),
        .host_ready     (host_ready),
        .host_rsp_valid (host_rsp_valid),
        .host_rsp       (host_rsp)
    );

    assign wb_data = ctrl.mem_rd ? load_data : alu_y;

    // One record per running cycle
    assign commit_valid   = run;
    assign commit.pc      = pc;
    assign commit.inst    = inst.raw;
    assign commit.rd      = rd;
    assign commit.rd_we   = rd_we;
    assign commit.rd_data = wb_data;

endmodule

// File: verif/single_cpu_checker.sv
`timescale 1ns/1ns

module single_cpu_checker import isa_pkg::*, cpu_pkg::*; (
    input logic    CLK,
    input logic    RST,
    input logic    host_valid,
    input logic    host_ready,
    input logic    host_rsp_valid,
    input logic    commit_valid,
    input commit_t commit
);

    int    fail_count = 0;  // Read by the testbench
    inst_u commit_inst;
    logic  store_commit;

    assign commit_inst  = commit.inst;
    assign store_commit = commit_valid && commit_inst.s.opcode == OPC_STORE
                          && commit_inst.s.funct3 == F3_WORD;

    rsp_after_accept: assert property (@(posedge CLK) disable iff (RST)
        host_rsp_valid |-> $past(host_valid && host_ready))
        else begin
            fail_count++;
            $error("host_rsp_valid without an accepted request one cycle earlier");
        end

    no_host_during_store: assert property (@(posedge CLK) disable iff (RST)
        store_commit |-> !host_ready)
        else begin
            fail_count++;
            $error("host_ready high while a store commits");
        end

    // Writes to x0 never reported
    no_x0_write: assert property (@(posedge CLK) disable iff (RST)
        commit_valid |-> !(commit.rd_we && commit.rd == 5'd0))
        else begin
            fail_count++;
            $error("commit reports rd_we with rd equal to x0");
        end

    quiet_in_reset: assert property (@(posedge CLK) RST |-> !commit_valid)
        else begin
            fail_count++;
            $error("commit_valid high during reset");
        end

endmodule

bind single_cpu single_cpu_checker checker_inst (
    .CLK            (CLK),
    .RST            (RST),
    .host_valid     (host_valid),
    .host_ready     (host_ready),
    .host_rsp_valid (host_rsp_valid),
    .commit_valid   (commit_valid),
    .commit         (commit)
);

// File: verif/single_cpu_tb.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module single_cpu_tb import isa_pkg::*, cpu_pkg::*; ();

    localparam int PERIOD          = 100;
    localparam int PROG_LEN        = 48;
    localparam int WATCHDOG_CYCLES = 2 + 2 * PROG_LEN + 2 * `DMEM_WORDS + 50;

    logic      CLK;
    logic      RST;
    logic      run;
    imem_wr_t  imem_wr;
    logic      host_valid;
    host_req_t host_req;
    logic      host_ready;
    logic      host_rsp_valid;
    host_rsp_t host_rsp;
    logic      commit_valid;
    commit_t   commit;

    logic [31:0] prog [`IMEM_WORDS];
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [`DMEM_WORDS];
    logic [31:0] exp_pc;
    int          commit_count;
    logic        host_phase;  // Halted and reading data memory

    single_cpu single_cpu_inst (.*);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        fail_run();
    end

    task automatic fail_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, want);
        fail_run();
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want)
            report_mismatch(name, {31'd0, got}, {31'd0, want});
    endtask

    task automatic check_word(input string name, input host_rsp_t got, input host_rsp_t want);
        if (got !== want)
            report_mismatch(name, got.data, want.data);
    endtask

    task automatic check_commit(input commit_t got, input commit_t want);
        if (got.pc !== want.pc) report_mismatch("commit.pc", got.pc, want.pc);
        if (got.inst !== want.inst) report_mismatch("commit.inst", got.inst, want.inst);
        if (got.rd !== want.rd) report_mismatch("commit.rd", {27'd0, got.rd}, {27'd0, want.rd});
        if (got.rd_we !== want.rd_we) check_flag("commit.rd_we", got.rd_we, want.rd_we);
        if (want.rd_we && got.rd_data !== want.rd_data)
            report_mismatch("commit.rd_data", got.rd_data, want.rd_data);
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        r_fmt_t r;
        r = '{f7, rs2, rs1, f3, rd, OPC_OP};
        return r;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        i_fmt_t i;
        i = '{imm, rs1, f3, rd, opc};
        return i;
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        s_fmt_t s;
        s = '{imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
        return s;
    endfunction

    // Registers x0..x7 only, so results feed each other
    function automatic logic [31:0] random_inst();
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [4:0]  base;
        f3   = 3'($urandom_range(0, 7));
        rd   = 5'($urandom_range(0, 7));
        rs1  = 5'($urandom_range(0, 7));
        rs2  = 5'($urandom_range(0, 7));
        imm  = 12'($urandom);
        base = $urandom_range(0, 1) ? 5'd0 : rs1;
        case ($urandom_range(0, 3))
            0: begin
                if ((f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) && $urandom_range(0, 1) == 1)
                    return enc_r(F7_ALT, rs2, rs1, f3, rd);
                return enc_r(F7_NORMAL, rs2, rs1, f3, rd);
            end
            1: begin
                if (f3 == F3_SLL)
                    imm[11:5] = F7_NORMAL;
                else if (f3 == F3_SRL_SRA)
                    imm[11:5] = $urandom_range(0, 1) ? F7_ALT : F7_NORMAL;
                return enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
            end
            2: return enc_i(12'(4 * $urandom_range(0, 7)), base, F3_WORD, rd, OPC_LOAD);
            default: return enc_s(12'(4 * $urandom_range(0, 7)), rs2, base);
        endcase
    endfunction

    function automatic logic is_word_store(input logic [31:0] word);
        inst_u w;
        w = word;
        return w.s.opcode == OPC_STORE && w.s.funct3 == F3_WORD;
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            F3_ADD_SUB: return alt ? a - b : a + b;
            F3_SLL:     return a << b[4:0];
            F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
            F3_XOR:     return a ^ b;
            F3_SRL_SRA: begin
                if (alt)
                    return $unsigned(sa >>> b[4:0]);  // Sign bit fills
                return a >> b[4:0];
            end
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    function automatic commit_t expect_commit(input logic [31:0] pc, input logic [31:0] word,
                                              input logic [31:0] regs [32],
                                              input logic [31:0] mem [`DMEM_WORDS]);
        inst_u       w;
        commit_t     c;
        logic [31:0] imm;
        logic [31:0] addr;
        logic        ok;
        logic        writes;
        w      = word;
        imm    = {{20{word[31]}}, word[31:20]};
        addr   = regs[w.i.rs1] + imm;
        c      = '0;
        c.pc   = pc;
        c.inst = word;
        ok     = 1'b0;
        writes = 1'b1;
        case (w.r.opcode)
            OPC_OP: begin
                ok = w.r.funct7 == F7_NORMAL || (w.r.funct7 == F7_ALT
                     && (w.r.funct3 == F3_ADD_SUB || w.r.funct3 == F3_SRL_SRA));
                c.rd_data = alu_ref(w.r.funct3, word[30], regs[w.r.rs1], regs[w.r.rs2]);
            end
            OPC_OP_IMM: begin
                if (w.i.funct3 == F3_SLL)
                    ok = word[31:25] == F7_NORMAL;
                else if (w.i.funct3 == F3_SRL_SRA)
                    ok = word[31:25] == F7_NORMAL || word[31:25] == F7_ALT;
                else
                    ok = 1'b1;
                c.rd_data = alu_ref(w.i.funct3, w.i.funct3 == F3_SRL_SRA && word[30],
                                    regs[w.i.rs1], imm);
            end
            OPC_LOAD: begin
                ok        = w.i.funct3 == F3_WORD;
                c.rd_data = mem[addr[`DMEM_AW+1:2]];
            end
            OPC_STORE: begin
                ok     = w.s.funct3 == F3_WORD;
                writes = 1'b0;
            end
            default: ok = 1'b0;  // Unsupported retires as a no-op
        endcase
        if (ok && writes)
            c.rd = w.r.rd;
        c.rd_we = ok && writes && c.rd != 5'd0;
        return c;
    endfunction

    task automatic apply_commit(input commit_t want);
        inst_u       w;
        logic [31:0] addr;
        w = want.inst;
        if (want.rd_we)
            model_regs[want.rd] = want.rd_data;
        if (w.s.opcode == OPC_STORE && w.s.funct3 == F3_WORD) begin
            addr = model_regs[w.s.rs1] + {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
            model_mem[addr[`DMEM_AW+1:2]] = model_regs[w.s.rs2];
        end
    endtask

    initial begin : stimulus
        logic      accepted;
        host_rsp_t want;
        void'($urandom(32'hfdd8));
        RST        = 1'b1;
        run        = 1'b0;
        imem_wr    = '0;
        host_valid = 1'b0;
        host_req   = '0;
        host_phase = 1'b0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        for (int i = 0; i < `DMEM_WORDS; i++) model_mem[i] = '0;
        for (int i = 0; i < `IMEM_WORDS; i++) prog[i] = '0;
        repeat (2) @(negedge CLK);
        RST = 1'b0;

        prog[0] = enc_i(12'hff9, 5'd0, F3_ADD_SUB, 5'd1, OPC_OP_IMM);  // x1 = -7
        prog[1] = enc_i(12'd3, 5'd0, F3_ADD_SUB, 5'd2, OPC_OP_IMM);
        prog[2] = enc_r(F7_ALT, 5'd2, 5'd1, F3_ADD_SUB, 5'd3);      // SUB
        prog[3] = enc_r(F7_NORMAL, 5'd2, 5'd1, F3_ADD_SUB, 5'd4);   // ADD, same operands
        prog[4] = enc_r(F7_ALT, 5'd2, 5'd1, F3_SRL_SRA, 5'd5);      // SRA
        prog[5] = enc_r(F7_NORMAL, 5'd2, 5'd1, F3_SRL_SRA, 5'd6);   // SRL
        prog[6] = enc_i({F7_ALT, 5'd2}, 5'd1, F3_SRL_SRA, 5'd7, OPC_OP_IMM);  // SRAI
        prog[7] = enc_r(F7_NORMAL, 5'd2, 5'd1, F3_ADD_SUB, 5'd0);   // Lost write to x0
        prog[8] = 32'h0000_037f;  // Opcode 7'h7f with rd x6
        for (int i = 9; i < PROG_LEN; i++) prog[i] = random_inst();

        for (int i = 0; i < PROG_LEN; i++) begin
            @(negedge CLK);
            imem_wr.en   = 1'b1;
            imem_wr.addr = i[`IMEM_AW-1:0];
            imem_wr.data = prog[i];
        end
        @(negedge CLK);
        imem_wr = '0;
        run     = 1'b1;
        while (commit_count < PROG_LEN) @(negedge CLK);
        run        = 1'b0;
        host_phase = 1'b1;

        for (int i = 0; i < `DMEM_WORDS; i++) begin
            @(negedge CLK);
            host_valid    = 1'b1;
            host_req.addr = i * 4;
            accepted      = 1'b0;
            while (!accepted) begin
                #(PERIOD / 4);
                accepted = host_ready;
                if (!accepted) @(negedge CLK);
            end
            check_flag("host_rsp_valid", host_rsp_valid, 1'b0);
            @(negedge CLK);
            host_valid = 1'b0;
            #(PERIOD / 4);
            check_flag("host_rsp_valid", host_rsp_valid, 1'b1);
            want.data = model_mem[i];
            check_word("host_rsp", host_rsp, want);
        end

        @(negedge CLK);
        if (single_cpu_inst.checker_inst.fail_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("An assertion in the bound checker failed");
            fail_run();
        end
    end

    // Sample a quarter period after the inputs change
    initial begin : compare
        commit_t want;
        exp_pc       = `RESET_PC;
        commit_count = 0;
        forever begin
            @(negedge CLK);
            #(PERIOD / 4);
            if (single_cpu_inst.checker_inst.fail_count != 0) begin
                $display("An assertion in the bound checker failed");
                fail_run();
            end
            if (RST || !run) begin
                check_flag("commit_valid", commit_valid, 1'b0);
                check_flag("host_ready", host_ready, 1'b1);  // No store while halted
                if (!host_phase)
                    check_flag("host_rsp_valid", host_rsp_valid, 1'b0);
            end else begin
                check_flag("commit_valid", commit_valid, 1'b1);
                want = expect_commit(exp_pc, prog[exp_pc[`IMEM_AW+1:2]], model_regs, model_mem);
                check_commit(commit, want);
                check_flag("host_ready", host_ready, !is_word_store(want.inst));
                apply_commit(want);
                exp_pc       = exp_pc + 32'd4;
                commit_count = commit_count + 1;
            end
        end
    end

endmodule

// File: flist.f
+incdir+src
src/isa_pkg.sv
src/cpu_pkg.sv
src/fetch_unit.sv
src/decoder.sv
src/reg_file.sv
src/alu.sv
src/data_mem.sv
src/single_cpu.sv
verif/single_cpu_checker.sv
verif/single_cpu_tb.sv

// File: Makefile
TOP := single_cpu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP)

# Assertion errors are counted by the testbench, so they must not stop the run
run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -q "TESTBENCH PASSED"

lint:
	verilator --lint-only -Wall --timing --assert -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
